//--- src.f
+incdir+design
+incdir+verification
design/imuldiv_msg_pkg.sv
design/imuldiv_fsm_pkg.sv
design/imuldiv_skid_buffer.sv
design/imuldiv_issue.sv
design/imuldiv_mul_iterative.sv
design/imuldiv_div_iterative.sv
design/imuldiv_unit.sv
verification/imuldiv_tb.sv

//--- verification/imuldiv_tb_checks.svh
// reference model for mul, div and divu
// typed compare tasks and the common error stop
`ifndef IMULDIV_TB_CHECKS_SVH
`define IMULDIV_TB_CHECKS_SVH

// --------------------------------------------------
// reference model
// --------------------------------------------------

// full signed product, both operands sign-extended to 64 bits
function automatic imuldiv_msg_pkg::resp_msg_t model_mul(
  input logic [`IMULDIV_XLEN-1:0] a,
  input logic [`IMULDIV_XLEN-1:0] b
);
  longint pa;
  longint pb;
  pa = $signed(a);
  pb = $signed(b);
  return pa * pb;
endfunction

// {remainder, quotient}
// zero divisor and signed overflow take the defined results
function automatic imuldiv_msg_pkg::resp_msg_t model_div(
  input logic [`IMULDIV_XLEN-1:0] a,
  input logic [`IMULDIV_XLEN-1:0] b,
  input logic                     is_signed
);
  int                       sa;
  int                       sb;
  logic [`IMULDIV_XLEN-1:0] q;
  logic [`IMULDIV_XLEN-1:0] r;
  sa = a;
  sb = b;
  if (b == '0) begin
    q = '1;
    r = a;
  end else if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
    q = 32'h8000_0000;
    r = '0;
  end else if (is_signed) begin
    // int division truncates, remainder keeps the dividend sign
    q = sa / sb;
    r = sa % sb;
  end else begin
    q = a / b;
    r = a % b;
  end
  return {r, q};
endfunction

// --------------------------------------------------
// error stop and compare tasks
// --------------------------------------------------
task automatic stop_on_error(input string why);
  $display("%s", why);
  $display("*** TEST FAILED ***");
  $fatal(1, "run stopped at first error");
endtask

task automatic check_product(
  input string                      name,
  input imuldiv_msg_pkg::resp_msg_t expected,
  input imuldiv_msg_pkg::resp_msg_t actual
);
  if (actual !== expected) begin
    stop_on_error($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
  end
endtask

// remainder and quotient shown apart
task automatic check_divrem(
  input string                      name,
  input imuldiv_msg_pkg::resp_msg_t expected,
  input imuldiv_msg_pkg::resp_msg_t actual
);
  if (actual !== expected) begin
    stop_on_error($sformatf("mismatch %s expected rem %h quo %h actual rem %h quo %h",
      name, expected[63:32], expected[31:0], actual[63:32], actual[31:0]));
  end
endtask

`endif

//--- verification/imuldiv_tb.sv
// testbench for the multiply/divide unit
// random requests with corner bias, response stalls, scoreboard, watchdog
`timescale 1ns/1ns
`default_nettype none

`include "imuldiv_consts.svh"

module imuldiv_tb;

  localparam int n_ops       = 400;
  // 40 cycles per op at 100 ns and twice that as margin
  localparam int watchdog_ns = n_ops * 40 * 100 * 2;
  // long output stall, longer than three back-to-back operations
  localparam int stall_period = 2000;
  localparam int stall_len    = 150;

  logic                       clk;
  logic                       reset;
  logic                       req_val;
  logic                       req_rdy;
  imuldiv_msg_pkg::op_t       req_op;
  logic [`IMULDIV_XLEN-1:0]   req_a;
  logic [`IMULDIV_XLEN-1:0]   req_b;
  logic                       resp_val;
  logic                       resp_rdy;
  imuldiv_msg_pkg::resp_msg_t resp_result;

  // scoreboard holds one entry per accepted request
  imuldiv_msg_pkg::resp_msg_t exp_q[$];
  imuldiv_msg_pkg::op_t       kind_q[$];
  string                      name_q[$];
  int                         rx_count;
  logic                       reset_done;

  `include "imuldiv_tb_checks.svh"

  imuldiv_unit uut (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  always #50 clk = ~clk;

  // operand with a bias toward 0, 1, -1, most negative and small values
  function automatic logic [`IMULDIV_XLEN-1:0] pick_operand();
    case ($urandom % 8)
      0: return 32'h0000_0000;
      1: return 32'h0000_0001;
      2: return 32'hffff_ffff;
      3: return 32'h8000_0000;
      4: return $urandom % 16;
      default: return $urandom;
    endcase
  endfunction

  // --------------------------------------------------
  // reset, request driver, end of run
  // --------------------------------------------------
  initial begin
    int gap;
    clk        = 1'b0;
    reset      = 1'b1;
    req_val    = 1'b0;
    req_op     = imuldiv_msg_pkg::mul;
    req_a      = '0;
    req_b      = '0;
    resp_rdy   = 1'b0;
    rx_count   = 0;
    reset_done = 1'b0;
    void'($urandom(32'hac75));
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    if (resp_val !== 1'b0) begin
      stop_on_error("resp_val is high in the cycle after reset");
    end
    if (req_rdy !== 1'b1) begin
      stop_on_error("req_rdy is low in the cycle after reset");
    end
    reset_done = 1'b1;
    for (int i = 0; i < n_ops; i++) begin
      gap = $urandom % 4;
      // a few fixed corners first and random ones after
      case (i)
        0: begin
          req_op = imuldiv_msg_pkg::div;
          req_a  = 32'h8000_0000;
          req_b  = 32'hffff_ffff;
        end
        1: begin
          req_op = imuldiv_msg_pkg::div;
          req_a  = $urandom;
          req_b  = '0;
        end
        2: begin
          req_op = imuldiv_msg_pkg::divu;
          req_a  = $urandom;
          req_b  = '0;
        end
        3: begin
          req_op = imuldiv_msg_pkg::mul;
          req_a  = 32'h8000_0000;
          req_b  = 32'h8000_0000;
        end
        default: begin
          req_op = imuldiv_msg_pkg::op_t'($urandom % 3);
          req_a  = pick_operand();
          req_b  = pick_operand();
        end
      endcase
      req_val = 1'b1;
      // req_rdy only moves after a rising edge so it is stable here
      while (!req_rdy) @(negedge clk);
      // transfer happens on the coming edge so the expected result is recorded now
      if (req_op == imuldiv_msg_pkg::mul) begin
        exp_q.push_back(model_mul(req_a, req_b));
      end else begin
        exp_q.push_back(model_div(req_a, req_b, req_op == imuldiv_msg_pkg::div));
      end
      kind_q.push_back(req_op);
      name_q.push_back($sformatf("%s #%0d", req_op.name(), i));
      @(negedge clk);
      req_val = 1'b0;
      repeat (gap) @(negedge clk);
    end
    wait (rx_count == n_ops);
    @(negedge clk);
    if (exp_q.size() == 0 && !resp_val) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      stop_on_error("extra response or unmatched request at end of run");
    end
  end

  // --------------------------------------------------
  // response side with random stalls and in-order checking
  // --------------------------------------------------
  initial begin
    imuldiv_msg_pkg::op_t kind;
    string                name;
    int                   cyc;
    wait (reset_done);
    cyc = 0;
    forever begin
      @(negedge clk);
      // a long stall now and then fills the output buffer
      // so a finished unit waits in done and the issue stage stays busy
      if ((cyc % stall_period) >= (stall_period - stall_len)) begin
        resp_rdy = 1'b0;
      end else begin
        // ready low about a third of the time
        resp_rdy = ($urandom % 3) != 0;
      end
      cyc++;
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          stop_on_error("response arrived with no request outstanding");
        end
        kind = kind_q.pop_front();
        name = name_q.pop_front();
        if (kind == imuldiv_msg_pkg::mul) begin
          check_product(name, exp_q.pop_front(), resp_result);
        end else begin
          check_divrem(name, exp_q.pop_front(), resp_result);
        end
        rx_count++;
      end
    end
  end

  // watchdog
  initial begin
    #(watchdog_ns);
    stop_on_error($sformatf("timeout, only %0d of %0d responses arrived", rx_count, n_ops));
  end

endmodule

`default_nettype wire

//--- design/imuldiv_unit.sv
// top level of the multiply/divide unit
// request buffer, issue stage, both iterative units, response buffer
`timescale 1ns/1ns
`default_nettype none

`include "imuldiv_consts.svh"

module imuldiv_unit (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  output logic                       req_rdy,
  input  imuldiv_msg_pkg::op_t       req_op,
  input  logic [`IMULDIV_XLEN-1:0]   req_a,
  input  logic [`IMULDIV_XLEN-1:0]   req_b,
  output logic                       resp_val,
  input  logic                       resp_rdy,
  output imuldiv_msg_pkg::resp_msg_t resp_result
);

  imuldiv_msg_pkg::req_msg_t req_msg;

  // input buffer to issue stage
  logic                      iq_val;
  logic                      iq_rdy;
  imuldiv_msg_pkg::req_msg_t iq_msg;

  // issue stage to output buffer
  logic                       oq_val;
  logic                       oq_rdy;
  imuldiv_msg_pkg::resp_msg_t oq_msg;

  // unit handshakes
  logic                       mul_req_val;
  logic                       mul_req_rdy;
  logic                       mul_resp_val;
  logic                       mul_resp_rdy;
  imuldiv_msg_pkg::resp_msg_t mul_resp_msg;
  logic                       div_req_val;
  logic                       div_req_rdy;
  logic                       div_signed;
  logic                       div_resp_val;
  logic                       div_resp_rdy;
  imuldiv_msg_pkg::resp_msg_t div_resp_msg;

  assign req_msg = '{op: req_op, a: req_a, b: req_b};

  // --------------------------------------------------
  // buffers and issue
  // --------------------------------------------------
  imuldiv_skid_buffer #(
    .payload_t (imuldiv_msg_pkg::req_msg_t)
  ) req_buf (
    .clk     (clk),
    .reset   (reset),
    .in_val  (req_val),
    .in_rdy  (req_rdy),
    .in_msg  (req_msg),
    .out_val (iq_val),
    .out_rdy (iq_rdy),
    .out_msg (iq_msg)
  );

  imuldiv_issue issue (
    .clk          (clk),
    .reset        (reset),
    .in_val       (iq_val),
    .in_rdy       (iq_rdy),
    .in_msg       (iq_msg),
    .mul_req_val  (mul_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .div_req_val  (div_req_val),
    .div_req_rdy  (div_req_rdy),
    .div_signed   (div_signed),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .mul_resp_msg (mul_resp_msg),
    .div_resp_val (div_resp_val),
    .div_resp_rdy (div_resp_rdy),
    .div_resp_msg (div_resp_msg),
    .out_val      (oq_val),
    .out_rdy      (oq_rdy),
    .out_msg      (oq_msg)
  );

  imuldiv_skid_buffer #(
    .payload_t (imuldiv_msg_pkg::resp_msg_t)
  ) resp_buf (
    .clk     (clk),
    .reset   (reset),
    .in_val  (oq_val),
    .in_rdy  (oq_rdy),
    .in_msg  (oq_msg),
    .out_val (resp_val),
    .out_rdy (resp_rdy),
    .out_msg (resp_result)
  );

  // --------------------------------------------------
  // iterative units, operands straight from the input buffer
  // --------------------------------------------------
  imuldiv_mul_iterative mul_unit (
    .clk         (clk),
    .reset       (reset),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .req_a       (iq_msg.a),
    .req_b       (iq_msg.b),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy),
    .resp_result (mul_resp_msg)
  );

  imuldiv_div_iterative div_unit (
    .clk         (clk),
    .reset       (reset),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .req_a       (iq_msg.a),
    .req_b       (iq_msg.b),
    .div_signed  (div_signed),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy),
    .resp_result (div_resp_msg)
  );

endmodule

`default_nettype wire

//--- design/imuldiv_div_iterative.sv
// signed/unsigned restoring divider, one quotient bit per cycle
// result is {remainder, quotient}, zero divisor handled at load
`timescale 1ns/1ns
`default_nettype none

`include "imuldiv_consts.svh"

module imuldiv_div_iterative (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  output logic                       req_rdy,
  input  logic [`IMULDIV_XLEN-1:0]   req_a,
  input  logic [`IMULDIV_XLEN-1:0]   req_b,
  input  logic                       div_signed,
  output logic                       resp_val,
  input  logic                       resp_rdy,
  output imuldiv_msg_pkg::resp_msg_t resp_result
);

  localparam int xlen = `IMULDIV_XLEN;
  localparam logic [`IMULDIV_CNT_W-1:0] cnt_init =
    (`IMULDIV_CNT_W)'(`IMULDIV_ITERS - 1);

  imuldiv_fsm_pkg::iter_state_t state;
  imuldiv_fsm_pkg::iter_state_t state_next;

  // remainder in the upper half, quotient shifts in below
  logic [2*xlen-1:0]         rq;
  logic [xlen-1:0]           dvsr;
  logic [`IMULDIV_CNT_W-1:0] cnt;
  logic                      neg_q;
  logic                      neg_r;

  logic            load;
  logic            step;
  logic            cnt_zero;
  logic            a_neg;
  logic            b_neg;
  logic            b_zero;
  logic [xlen-1:0] a_load;
  logic [xlen-1:0] b_load;
  logic [xlen:0]   part;
  logic [xlen:0]   diff;
  logic [xlen-1:0] quo;
  logic [xlen-1:0] rem;

  // --------------------------------------------------
  // control
  // --------------------------------------------------
  assign req_rdy  = (state == imuldiv_fsm_pkg::idle);
  assign resp_val = (state == imuldiv_fsm_pkg::done);
  assign load     = req_val && req_rdy;
  assign step     = (state == imuldiv_fsm_pkg::calc);
  assign cnt_zero = (cnt == '0);

  always_comb begin
    state_next = state;
    case (state)
      imuldiv_fsm_pkg::idle: begin
        if (load) begin
          state_next = imuldiv_fsm_pkg::calc;
        end
      end
      imuldiv_fsm_pkg::calc: begin
        if (cnt_zero) begin
          state_next = imuldiv_fsm_pkg::done;
        end
      end
      imuldiv_fsm_pkg::done: begin
        // hold result until the issue stage takes it
        if (resp_rdy) begin
          state_next = imuldiv_fsm_pkg::idle;
        end
      end
      default: state_next = imuldiv_fsm_pkg::idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_fsm_pkg::idle;
    end else begin
      state <= state_next;
    end
  end

  // --------------------------------------------------
  // load-side operand conditioning
  // --------------------------------------------------
  assign a_neg  = div_signed && req_a[xlen-1];
  assign b_neg  = div_signed && req_b[xlen-1];
  assign b_zero = (req_b == '0);

  // zero divisor keeps the raw dividend: every step then succeeds,
  // leaving the dividend as remainder and all ones as quotient
  assign a_load = (a_neg && !b_zero) ? (~req_a + 1'b1) : req_a;
  assign b_load = b_neg ? (~req_b + 1'b1) : req_b;

  // --------------------------------------------------
  // restoring step
  // --------------------------------------------------
  // shifted partial remainder, 33 bits so nothing is lost
  assign part = rq[2*xlen-1:xlen-1];
  // msb of diff set means borrow, keep the old remainder
  assign diff = part - {1'b0, dvsr};

  always_ff @(posedge clk) begin
    if (load) begin
      rq    <= {{xlen{1'b0}}, a_load};
      dvsr  <= b_load;
      cnt   <= cnt_init;
      neg_q <= (a_neg ^ b_neg) && !b_zero;
      neg_r <= a_neg && !b_zero;
    end else if (step) begin
      if (diff[xlen]) begin
        rq <= {rq[2*xlen-2:0], 1'b0};
      end else begin
        rq <= {diff[xlen-1:0], rq[xlen-2:0], 1'b1};
      end
      cnt <= cnt - 1'b1;
    end
  end

  // sign fix-up
  // quotient takes xor of signs, remainder follows the dividend
  assign quo = neg_q ? (~rq[xlen-1:0] + 1'b1) : rq[xlen-1:0];
  assign rem = neg_r ? (~rq[2*xlen-1:xlen] + 1'b1) : rq[2*xlen-1:xlen];

  assign resp_result = {rem, quo};

endmodule

`default_nettype wire

//--- design/imuldiv_mul_iterative.sv
// signed 32x32 shift-and-add multiplier
// control FSM and datapath in one module
`timescale 1ns/1ns
`default_nettype none

`include "imuldiv_consts.svh"

module imuldiv_mul_iterative (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  output logic                       req_rdy,
  input  logic [`IMULDIV_XLEN-1:0]   req_a,
  input  logic [`IMULDIV_XLEN-1:0]   req_b,
  output logic                       resp_val,
  input  logic                       resp_rdy,
  output imuldiv_msg_pkg::resp_msg_t resp_result
);

  localparam int xlen = `IMULDIV_XLEN;
  // counter value loaded with the operands
  localparam logic [`IMULDIV_CNT_W-1:0] cnt_init =
    (`IMULDIV_CNT_W)'(`IMULDIV_ITERS - 1);

  imuldiv_fsm_pkg::iter_state_t state;
  imuldiv_fsm_pkg::iter_state_t state_next;

  // datapath registers
  logic [2*xlen-1:0]         mcand;
  logic [xlen-1:0]           mplier;
  logic [2*xlen-1:0]         prod;
  logic [`IMULDIV_CNT_W-1:0] cnt;
  logic                      neg;

  logic              load;
  logic              step;
  logic              cnt_zero;
  logic [xlen-1:0]   a_mag;
  logic [xlen-1:0]   b_mag;
  logic [2*xlen-1:0] prod_next;

  // --------------------------------------------------
  // control
  // --------------------------------------------------
  assign req_rdy  = (state == imuldiv_fsm_pkg::idle);
  assign resp_val = (state == imuldiv_fsm_pkg::done);
  assign load     = req_val && req_rdy;
  assign step     = (state == imuldiv_fsm_pkg::calc);
  assign cnt_zero = (cnt == '0);

  // load on the request edge, then 32 iteration edges
  always_comb begin
    state_next = state;
    case (state)
      imuldiv_fsm_pkg::idle: begin
        if (load) begin
          state_next = imuldiv_fsm_pkg::calc;
        end
      end
      imuldiv_fsm_pkg::calc: begin
        // last iteration when the counter hits zero
        if (cnt_zero) begin
          state_next = imuldiv_fsm_pkg::done;
        end
      end
      imuldiv_fsm_pkg::done: begin
        if (resp_rdy) begin
          state_next = imuldiv_fsm_pkg::idle;
        end
      end
      default: state_next = imuldiv_fsm_pkg::idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_fsm_pkg::idle;
    end else begin
      state <= state_next;
    end
  end

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------
  // operands as magnitudes, sign kept apart
  assign a_mag = req_a[xlen-1] ? (~req_a + 1'b1) : req_a;
  assign b_mag = req_b[xlen-1] ? (~req_b + 1'b1) : req_b;

  // add shifted multiplicand when the multiplier lsb is set
  assign prod_next = mplier[0] ? (prod + mcand) : prod;

  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {{xlen{1'b0}}, a_mag};
      mplier <= b_mag;
      prod   <= '0;
      cnt    <= cnt_init;
      neg    <= req_a[xlen-1] ^ req_b[xlen-1];
    end else if (step) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
      prod   <= prod_next;
      cnt    <= cnt - 1'b1;
    end
  end

  // negate when exactly one operand was negative
  assign resp_result = neg ? (~prod + 1'b1) : prod;

endmodule

`default_nettype wire

//--- design/imuldiv_issue.sv
// issue stage: steers requests by opcode to the multiplier or divider
// and returns the owning unit's response
`timescale 1ns/1ns
`default_nettype none

module imuldiv_issue (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       in_val,
  output logic                       in_rdy,
  input  imuldiv_msg_pkg::req_msg_t  in_msg,
  output logic                       mul_req_val,
  input  logic                       mul_req_rdy,
  output logic                       div_req_val,
  input  logic                       div_req_rdy,
  output logic                       div_signed,
  input  logic                       mul_resp_val,
  output logic                       mul_resp_rdy,
  input  imuldiv_msg_pkg::resp_msg_t mul_resp_msg,
  input  logic                       div_resp_val,
  output logic                       div_resp_rdy,
  input  imuldiv_msg_pkg::resp_msg_t div_resp_msg,
  output logic                       out_val,
  input  logic                       out_rdy,
  output imuldiv_msg_pkg::resp_msg_t out_msg
);

  imuldiv_fsm_pkg::issue_state_t state;

  logic is_mul;
  logic is_free;
  logic in_go;
  logic out_go;

  // --------------------------------------------------
  // request side
  // --------------------------------------------------
  // single opcode decode, units never see op
  assign is_mul     = (in_msg.op == imuldiv_msg_pkg::mul);
  assign div_signed = (in_msg.op == imuldiv_msg_pkg::div);
  assign is_free    = (state == imuldiv_fsm_pkg::free);

  // forward in the same cycle while free
  assign mul_req_val = is_free && in_val && is_mul;
  assign div_req_val = is_free && in_val && !is_mul;
  assign in_rdy      = is_free && (is_mul ? mul_req_rdy : div_req_rdy);
  assign in_go       = in_val && in_rdy;

  // --------------------------------------------------
  // response side, combinational mux on owner
  // --------------------------------------------------
  always_comb begin
    out_val      = 1'b0;
    out_msg      = mul_resp_msg;
    mul_resp_rdy = 1'b0;
    div_resp_rdy = 1'b0;
    case (state)
      imuldiv_fsm_pkg::busy_mul: begin
        out_val      = mul_resp_val;
        mul_resp_rdy = out_rdy;
      end
      imuldiv_fsm_pkg::busy_div: begin
        out_val      = div_resp_val;
        out_msg      = div_resp_msg;
        div_resp_rdy = out_rdy;
      end
      default: begin
      end
    endcase
  end

  assign out_go = out_val && out_rdy;

  // owner record, cleared when the response leaves
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_fsm_pkg::free;
    end else if (is_free && in_go) begin
      state <= is_mul ? imuldiv_fsm_pkg::busy_mul : imuldiv_fsm_pkg::busy_div;
    end else if (out_go) begin
      state <= imuldiv_fsm_pkg::free;
    end
  end

endmodule

`default_nettype wire

//--- design/imuldiv_skid_buffer.sv
// two-entry valid/ready buffer, payload type given by parameter
`timescale 1ns/1ns
`default_nettype none

module imuldiv_skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_val,
  output logic     in_rdy,
  input  payload_t in_msg,
  output logic     out_val,
  input  logic     out_rdy,
  output payload_t out_msg
);

  // two slots, one-bit pointers wrap on their own
  payload_t   entry [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;

  logic do_enq;
  logic do_deq;

  // ready from fill level only, so no path from out_rdy
  assign in_rdy  = (count != 2'd2);
  assign out_val = (count != 2'd0);
  assign out_msg = entry[rd_ptr];

  assign do_enq = in_val && in_rdy;
  assign do_deq = out_val && out_rdy;

  // --------------------------------------------------
  // pointers and fill count
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (do_enq) begin
        wr_ptr <= ~wr_ptr;
      end
      if (do_deq) begin
        rd_ptr <= ~rd_ptr;
      end
      // enq and deq together leave the count alone
      case ({do_enq, do_deq})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  // payload slots, written on enqueue only
  always_ff @(posedge clk) begin
    if (do_enq) begin
      entry[wr_ptr] <= in_msg;
    end
  end

endmodule

`default_nettype wire

//--- design/imuldiv_fsm_pkg.sv
// state encodings for the iterative units and the issue stage
`default_nettype none

package imuldiv_fsm_pkg;

  // iterative unit control: wait, iterate, hold result
  typedef enum logic [1:0] {
    idle = 2'd0,
    calc = 2'd1,
    done = 2'd2
  } iter_state_t;

  // issue stage: which unit owns the operation in flight
  typedef enum logic [1:0] {
    free     = 2'd0,
    busy_mul = 2'd1,
    busy_div = 2'd2
  } issue_state_t;

endpackage

`default_nettype wire

//--- design/imuldiv_msg_pkg.sv
// request and response message types
// opcode encoding for mul, div and divu
`default_nettype none

`include "imuldiv_consts.svh"

package imuldiv_msg_pkg;

  // operation select, encoding 3 unused
  typedef enum logic [1:0] {
    mul  = 2'd0,
    div  = 2'd1,
    divu = 2'd2
  } op_t;

  // request: opcode plus both operands, 66 bits
  typedef struct packed {
    op_t                      op;
    logic [`IMULDIV_XLEN-1:0] a;
    logic [`IMULDIV_XLEN-1:0] b;
  } req_msg_t;

  // response word
  // mul gives the full product
  // div and divu give {remainder, quotient}
  typedef logic [2*`IMULDIV_XLEN-1:0] resp_msg_t;

endpackage

`default_nettype wire

//--- design/imuldiv_consts.svh
// operand width, iteration count and counter width
// shared by the message package and the iterative units
`ifndef IMULDIV_CONSTS_SVH
`define IMULDIV_CONSTS_SVH

// --------------------------------------------------
// datapath sizing
// --------------------------------------------------

// operand width in bits
`define IMULDIV_XLEN 32

// one product or quotient bit per iteration
`define IMULDIV_ITERS 32

// counter only has to hold ITERS-1
`define IMULDIV_CNT_W 5

`endif
